// ==== source/turf_pkg.sv ====
`default_nettype none

package turf_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus and crate geometry
    //////////////////////////////////////////////////////////////////////

    localparam int ADDR_W        = 28;
    localparam int DATA_W        = 32;
    localparam int CRATE_ADDR_W  = 27;
    localparam int LOCAL_ADDR_W  = 14;
    localparam int NUM_LINKS     = 4;
    localparam int LINK_SEL_W    = $clog2(NUM_LINKS);
    // Register address within one TURFIO link
    localparam int LINK_REG_W    = CRATE_ADDR_W - LINK_SEL_W;
    localparam int BRIDGE_TYPE_W = 2;
    localparam int BRIDGE_SEL_W  = NUM_LINKS * BRIDGE_TYPE_W;

    // Bridge type codes, 2 and 3 are reserved
    localparam logic [BRIDGE_TYPE_W-1:0] BRIDGE_NONE   = 2'd0;
    localparam logic [BRIDGE_TYPE_W-1:0] BRIDGE_AURORA = 2'd1;

    //////////////////////////////////////////////////////////////////////
    // Identity and local register map
    //////////////////////////////////////////////////////////////////////

    localparam logic [DATA_W-1:0] IDENT_WORD    = "TURF";
    localparam logic              REV_B         = 1'b1;
    localparam logic [14:0]       FW_DATE       = 15'h0A31;
    localparam logic [3:0]        VER_MAJOR     = 4'd0;
    localparam logic [3:0]        VER_MINOR     = 4'd8;
    localparam logic [7:0]        VER_REV       = 8'd2;
    localparam logic [DATA_W-1:0] DATEVERSION_WORD =
        {REV_B, FW_DATE, VER_MAJOR, VER_MINOR, VER_REV};

    localparam logic [LOCAL_ADDR_W-1:0] REG_IDENT       = 14'h0000;
    localparam logic [LOCAL_ADDR_W-1:0] REG_DATEVERSION = 14'h0004;
    localparam logic [LOCAL_ADDR_W-1:0] REG_BRIDGE_TYPE = 14'h0008;
    // Timeout flags 3..0, invalid flags 11..8, write one to clear
    localparam logic [LOCAL_ADDR_W-1:0] REG_BRIDGE_STAT = 14'h000C;
    localparam logic [LOCAL_ADDR_W-1:0] REG_LINK_UP     = 14'h0010;

    //////////////////////////////////////////////////////////////////////
    // Crate bridge
    //////////////////////////////////////////////////////////////////////

    localparam int BRIDGE_TIMEOUT_CYCLES = 64;
    localparam int TIMEOUT_CNT_W         = $clog2(BRIDGE_TIMEOUT_CYCLES);
    localparam int CMD_CREDITS           = 4;
    localparam int CREDIT_CNT_W          = $clog2(CMD_CREDITS + 1);

    localparam logic [DATA_W-1:0] INVALID_READ_DATA = 32'hDEADBEEF;
    localparam logic [DATA_W-1:0] TIMEOUT_READ_DATA = 32'hBADC0FFE;

    // Sequencer state codes
    localparam logic [2:0] BR_IDLE   = 3'd0;
    localparam logic [2:0] BR_HEADER = 3'd1;
    localparam logic [2:0] BR_DATA   = 3'd2;
    localparam logic [2:0] BR_WAIT   = 3'd3;
    localparam logic [2:0] BR_ACK    = 3'd4;

    // One command word, either a header or the write data
    typedef union packed {
        struct packed {
            logic                         is_write;
            logic [DATA_W-LINK_REG_W-2:0] spare;
            logic [LINK_REG_W-1:0]        reg_addr;
        } hdr;
        logic [DATA_W-1:0] raw;
    } cmd_word_u;

endpackage

`default_nettype wire

// ==== source/cmd_credit_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_credit_tx (
    input  wire                              ps_clk,
    input  wire                              rst_n_i,
    input  wire                              word_valid_i,
    input  wire turf_pkg::cmd_word_u         word_i,
    input  wire [turf_pkg::LINK_SEL_W-1:0]   dest_i,
    input  wire                              last_i,
    input  wire                              cmd_credit_i,
    output logic                             word_ready_o,
    output logic                             cmd_valid_o,
    output logic [turf_pkg::DATA_W-1:0]      cmd_data_o,
    output logic [turf_pkg::LINK_SEL_W-1:0]  cmd_dest_o,
    output logic                             cmd_last_o
);
    import turf_pkg::*;

    logic [CREDIT_CNT_W-1:0] credit_q;
    logic                    full_q;
    cmd_word_u               word_q;
    logic [LINK_SEL_W-1:0]   dest_q;
    logic                    last_q;
    logic                    send;
    logic                    take;

    // A held word goes out as soon as the far end has buffer space
    assign send         = full_q && (credit_q != '0);
    assign word_ready_o = !full_q || send;
    assign take         = word_valid_i && word_ready_o;

    assign cmd_valid_o = send;
    assign cmd_data_o  = word_q.raw;
    assign cmd_dest_o  = dest_q;
    assign cmd_last_o  = send && last_q;

    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            full_q   <= 1'b0;
            credit_q <= CREDIT_CNT_W'(CMD_CREDITS);
        end else begin
            if (take) begin
                full_q <= 1'b1;
            end else if (send) begin
                full_q <= 1'b0;
            end
            case ({send, cmd_credit_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

    always_ff @(posedge ps_clk) begin
        if (take) begin
            word_q <= word_i;
            dest_q <= dest_i;
            last_q <= last_i;
        end
    end

    credit_bound : assert property (
        @(posedge ps_clk) disable iff (!rst_n_i)
        credit_q <= CREDIT_CNT_W'(CMD_CREDITS)
    );

    no_send_empty : assert property (
        @(posedge ps_clk) disable iff (!rst_n_i)
        $rose(cmd_valid_o) |-> credit_q != '0
    );

endmodule

`default_nettype wire

// ==== source/crate_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module crate_bridge (
    input  wire                                ps_clk,
    input  wire                                rst_n_i,
    input  wire                                req_i,
    input  wire                                we_i,
    input  wire [turf_pkg::CRATE_ADDR_W-1:0]   addr_i,
    input  wire [turf_pkg::DATA_W-1:0]         wdata_i,
    input  wire [turf_pkg::BRIDGE_SEL_W-1:0]   bridge_type_i,
    input  wire [turf_pkg::NUM_LINKS-1:0]      link_up_i,
    input  wire                                cmd_credit_i,
    input  wire                                resp_valid_i,
    input  wire [turf_pkg::DATA_W-1:0]         resp_data_i,
    output logic                               ack_o,
    output logic                               err_o,
    output logic [turf_pkg::DATA_W-1:0]        rdata_o,
    output logic [turf_pkg::NUM_LINKS-1:0]     timeout_o,
    output logic [turf_pkg::NUM_LINKS-1:0]     invalid_o,
    output logic                               cmd_valid_o,
    output logic [turf_pkg::DATA_W-1:0]        cmd_data_o,
    output logic [turf_pkg::LINK_SEL_W-1:0]    cmd_dest_o,
    output logic                               cmd_last_o
);
    import turf_pkg::*;

    logic [2:0]               state_q;
    logic [TIMEOUT_CNT_W-1:0] cnt_q;
    logic [LINK_SEL_W-1:0]    link_sel;
    logic [NUM_LINKS-1:0]     link_onehot;
    logic                     access_ok;
    logic                     word_valid;
    logic                     word_ready;
    logic                     word_last;
    cmd_word_u                word;

    //////////////////////////////////////////////////////////////////////
    // Access check
    //////////////////////////////////////////////////////////////////////

    // Address fields stay stable until ack, so they are used directly
    assign link_sel    = addr_i[CRATE_ADDR_W-1 -: LINK_SEL_W];
    assign link_onehot = {{(NUM_LINKS-1){1'b0}}, 1'b1} << link_sel;
    assign access_ok   =
        (bridge_type_i[link_sel*BRIDGE_TYPE_W +: BRIDGE_TYPE_W] == BRIDGE_AURORA) &&
        link_up_i[link_sel];

    // Header first, then write data for a write
    assign word_valid = (state_q == BR_HEADER) || (state_q == BR_DATA);
    assign word_last  = (state_q == BR_DATA) || !we_i;

    always_comb begin
        word = '0;
        if (state_q == BR_DATA) begin
            word.raw = wdata_i;
        end else begin
            word.hdr.is_write = we_i;
            word.hdr.reg_addr = addr_i[LINK_REG_W-1:0];
        end
    end

    assign ack_o = (state_q == BR_ACK);

    //////////////////////////////////////////////////////////////////////
    // Sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= BR_IDLE;
            cnt_q     <= '0;
            err_o     <= 1'b0;
            rdata_o   <= '0;
            timeout_o <= '0;
            invalid_o <= '0;
        end else begin
            timeout_o <= '0;
            invalid_o <= '0;
            case (state_q)
                BR_IDLE: begin
                    cnt_q <= '0;
                    if (req_i && access_ok) begin
                        state_q <= BR_HEADER;
                    end else if (req_i) begin
                        state_q   <= BR_ACK;
                        err_o     <= 1'b1;
                        rdata_o   <= INVALID_READ_DATA;
                        invalid_o <= link_onehot;
                    end
                end
                BR_HEADER: begin
                    if (word_ready) begin
                        state_q <= we_i ? BR_DATA : BR_WAIT;
                    end
                end
                BR_DATA: begin
                    if (word_ready) begin
                        state_q <= BR_WAIT;
                    end
                end
                BR_WAIT: begin
                    if (resp_valid_i) begin
                        state_q <= BR_ACK;
                        rdata_o <= resp_data_i;
                    end else if (cnt_q == TIMEOUT_CNT_W'(BRIDGE_TIMEOUT_CYCLES - 1)) begin
                        state_q   <= BR_ACK;
                        err_o     <= 1'b1;
                        rdata_o   <= TIMEOUT_READ_DATA;
                        timeout_o <= link_onehot;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                BR_ACK: begin
                    // Return to zero so the top level can OR the two spaces
                    state_q <= BR_IDLE;
                    err_o   <= 1'b0;
                    rdata_o <= '0;
                end
                default: state_q <= BR_IDLE;
            endcase
        end
    end

    cmd_credit_tx u_cmd_tx (
        .ps_clk       (ps_clk),
        .rst_n_i      (rst_n_i),
        .word_valid_i (word_valid),
        .word_i       (word),
        .dest_i       (link_sel),
        .last_i       (word_last),
        .cmd_credit_i (cmd_credit_i),
        .word_ready_o (word_ready),
        .cmd_valid_o  (cmd_valid_o),
        .cmd_data_o   (cmd_data_o),
        .cmd_dest_o   (cmd_dest_o),
        .cmd_last_o   (cmd_last_o)
    );

    status_pulses_exclusive : assert property (
        @(posedge ps_clk) disable iff (!rst_n_i)
        !(|timeout_o && |invalid_o) && $onehot0(timeout_o) && $onehot0(invalid_o)
    );

endmodule

`default_nettype wire

// ==== source/turf_id_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module turf_id_ctrl (
    input  wire                                ps_clk,
    input  wire                                rst_n_i,
    input  wire                                req_i,
    input  wire                                we_i,
    input  wire [turf_pkg::LOCAL_ADDR_W-1:0]   addr_i,
    input  wire [turf_pkg::DATA_W-1:0]         wdata_i,
    input  wire [turf_pkg::NUM_LINKS-1:0]      link_up_i,
    input  wire [turf_pkg::NUM_LINKS-1:0]      bridge_timeout_i,
    input  wire [turf_pkg::NUM_LINKS-1:0]      bridge_invalid_i,
    output logic                               ack_o,
    output logic                               err_o,
    output logic [turf_pkg::DATA_W-1:0]        rdata_o,
    output logic [turf_pkg::BRIDGE_SEL_W-1:0]  bridge_type_o
);
    import turf_pkg::*;

    logic                 acc;
    logic                 wr;
    logic                 hit;
    logic [DATA_W-1:0]    rd_mux;
    logic [NUM_LINKS-1:0] timeout_flags;
    logic [NUM_LINKS-1:0] invalid_flags;
    logic [NUM_LINKS-1:0] clr_timeout;
    logic [NUM_LINKS-1:0] clr_invalid;

    // First cycle of a request only, the master holds req until ack
    assign acc = req_i && !ack_o;
    assign wr  = acc && we_i;

    always_comb begin
        hit    = 1'b1;
        rd_mux = '0;
        case (addr_i)
            REG_IDENT:       rd_mux = IDENT_WORD;
            REG_DATEVERSION: rd_mux = DATEVERSION_WORD;
            REG_BRIDGE_TYPE: rd_mux[BRIDGE_SEL_W-1:0] = bridge_type_o;
            REG_BRIDGE_STAT: begin
                rd_mux[NUM_LINKS-1:0]  = timeout_flags;
                rd_mux[8 +: NUM_LINKS] = invalid_flags;
            end
            REG_LINK_UP:     rd_mux[NUM_LINKS-1:0] = link_up_i;
            default:         hit = 1'b0;
        endcase
    end

    always_comb begin
        clr_timeout = '0;
        clr_invalid = '0;
        if (wr && addr_i == REG_BRIDGE_STAT) begin
            clr_timeout = wdata_i[NUM_LINKS-1:0];
            clr_invalid = wdata_i[8 +: NUM_LINKS];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Control registers and sticky status
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o         <= 1'b0;
            err_o         <= 1'b0;
            bridge_type_o <= {NUM_LINKS{BRIDGE_NONE}};
            timeout_flags <= '0;
            invalid_flags <= '0;
        end else begin
            ack_o <= acc;
            err_o <= acc && !hit;
            if (wr && addr_i == REG_BRIDGE_TYPE) begin
                bridge_type_o <= wdata_i[BRIDGE_SEL_W-1:0];
            end
            // A new event wins over a clear in the same cycle
            timeout_flags <= (timeout_flags & ~clr_timeout) | bridge_timeout_i;
            invalid_flags <= (invalid_flags & ~clr_invalid) | bridge_invalid_i;
        end
    end

    // Zero outside the ack cycle so the top can OR both spaces
    always_ff @(posedge ps_clk) begin
        rdata_o <= (acc && !we_i) ? rd_mux : '0;
    end

    ack_follows_req : assert property (
        @(posedge ps_clk) disable iff (!rst_n_i)
        ack_o |-> $past(req_i)
    );

endmodule

`default_nettype wire

// ==== source/turf_reg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module turf_reg_top (
    input  wire                              ps_clk,
    input  wire                              rst_n_i,
    input  wire                              bus_req_i,
    input  wire                              bus_we_i,
    input  wire [turf_pkg::ADDR_W-1:0]       bus_addr_i,
    input  wire [turf_pkg::DATA_W-1:0]       bus_wdata_i,
    input  wire [turf_pkg::NUM_LINKS-1:0]    link_up_i,
    input  wire                              cmd_credit_i,
    input  wire                              resp_valid_i,
    input  wire [turf_pkg::DATA_W-1:0]       resp_data_i,
    output logic                             bus_ack_o,
    output logic                             bus_err_o,
    output logic [turf_pkg::DATA_W-1:0]      bus_rdata_o,
    output logic                             cmd_valid_o,
    output logic [turf_pkg::DATA_W-1:0]      cmd_data_o,
    output logic [turf_pkg::LINK_SEL_W-1:0]  cmd_dest_o,
    output logic                             cmd_last_o
);
    import turf_pkg::*;

    logic                    crate_sel;
    logic                    loc_ack;
    logic                    loc_err;
    logic [DATA_W-1:0]       loc_rdata;
    logic                    crate_ack;
    logic                    crate_err;
    logic [DATA_W-1:0]       crate_rdata;
    logic [BRIDGE_SEL_W-1:0] bridge_type;
    logic [NUM_LINKS-1:0]    bridge_timeout;
    logic [NUM_LINKS-1:0]    bridge_invalid;

    // Top address bit picks crate space over the local registers
    assign crate_sel = bus_addr_i[ADDR_W-1];

    // Idle side always returns zeros
    assign bus_ack_o   = loc_ack | crate_ack;
    assign bus_err_o   = loc_err | crate_err;
    assign bus_rdata_o = loc_rdata | crate_rdata;

    turf_id_ctrl u_id_ctrl (
        .ps_clk           (ps_clk),
        .rst_n_i          (rst_n_i),
        .req_i            (bus_req_i && !crate_sel),
        .we_i             (bus_we_i),
        .addr_i           (bus_addr_i[LOCAL_ADDR_W-1:0]),
        .wdata_i          (bus_wdata_i),
        .link_up_i        (link_up_i),
        .bridge_timeout_i (bridge_timeout),
        .bridge_invalid_i (bridge_invalid),
        .ack_o            (loc_ack),
        .err_o            (loc_err),
        .rdata_o          (loc_rdata),
        .bridge_type_o    (bridge_type)
    );

    crate_bridge u_bridge (
        .ps_clk        (ps_clk),
        .rst_n_i       (rst_n_i),
        .req_i         (bus_req_i && crate_sel),
        .we_i          (bus_we_i),
        .addr_i        (bus_addr_i[CRATE_ADDR_W-1:0]),
        .wdata_i       (bus_wdata_i),
        .bridge_type_i (bridge_type),
        .link_up_i     (link_up_i),
        .cmd_credit_i  (cmd_credit_i),
        .resp_valid_i  (resp_valid_i),
        .resp_data_i   (resp_data_i),
        .ack_o         (crate_ack),
        .err_o         (crate_err),
        .rdata_o       (crate_rdata),
        .timeout_o     (bridge_timeout),
        .invalid_o     (bridge_invalid),
        .cmd_valid_o   (cmd_valid_o),
        .cmd_data_o    (cmd_data_o),
        .cmd_dest_o    (cmd_dest_o),
        .cmd_last_o    (cmd_last_o)
    );

endmodule

`default_nettype wire

// ==== verif/crate_link_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module crate_link_model #(
    parameter int SEED = 0
) (
    input  wire                              ps_clk,
    input  wire                              rst_n_i,
    input  wire                              mute_i,
    input  wire                              cmd_valid_i,
    input  wire [turf_pkg::DATA_W-1:0]       cmd_data_i,
    input  wire [turf_pkg::LINK_SEL_W-1:0]   cmd_dest_i,
    input  wire                              cmd_last_i,
    output logic                             credit_o,
    output logic                             resp_valid_o,
    output logic [turf_pkg::DATA_W-1:0]      resp_data_o
);
    import turf_pkg::*;

    // Buffer entry is {last, dest, data}
    logic [DATA_W+LINK_SEL_W:0] buf_q [$];
    logic [DATA_W+LINK_SEL_W:0] entry;
    logic [DATA_W-1:0]          regs [NUM_LINKS][16];
    logic [LINK_SEL_W-1:0]      dest;
    cmd_word_u                  hdr;
    logic                       in_write;
    int                         seed;

    initial begin
        seed = SEED;
        for (int l = 0; l < NUM_LINKS; l++) begin
            for (int i = 0; i < 16; i++) begin
                regs[l][i] = {16'hC0DE, 8'(l), 8'(i)};
            end
        end
    end

    always @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credit_o     <= 1'b0;
            resp_valid_o <= 1'b0;
            resp_data_o  <= '0;
            buf_q.delete();
            in_write = 1'b0;
        end else begin
            credit_o     <= 1'b0;
            resp_valid_o <= 1'b0;
            if (cmd_valid_i) begin
                buf_q.push_back({cmd_last_i, cmd_dest_i, cmd_data_i});
            end
            // Drain at a random rate, one credit back per drained word
            if (buf_q.size() != 0 && ($random(seed) & 1) != 0) begin
                entry    = buf_q.pop_front();
                dest     = entry[DATA_W +: LINK_SEL_W];
                credit_o <= 1'b1;
                if (in_write) begin
                    regs[dest][hdr.hdr.reg_addr[3:0]] = entry[DATA_W-1:0];
                    in_write = 1'b0;
                    if (!mute_i) begin
                        resp_valid_o <= 1'b1;
                        resp_data_o  <= '0;
                    end
                end else begin
                    hdr.raw  = entry[DATA_W-1:0];
                    in_write = hdr.hdr.is_write;
                    // A read is complete with its header
                    if (!hdr.hdr.is_write && !mute_i) begin
                        resp_valid_o <= 1'b1;
                        resp_data_o  <= regs[dest][hdr.hdr.reg_addr[3:0]];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_turf_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_turf_reg;
    import turf_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_TXN    = 40;
    localparam int SEED       = 32'h56bf;

    logic                  ps_clk;
    logic                  rst_n;
    logic                  bus_req;
    logic                  bus_we;
    logic [ADDR_W-1:0]     bus_addr;
    logic [DATA_W-1:0]     bus_wdata;
    logic [NUM_LINKS-1:0]  link_up;
    logic                  mute;
    logic                  cmd_credit;
    logic                  resp_valid;
    logic [DATA_W-1:0]     resp_data;
    wire                   bus_ack_o;
    wire                   bus_err_o;
    wire [DATA_W-1:0]      bus_rdata_o;
    wire                   cmd_valid_o;
    wire [DATA_W-1:0]      cmd_data_o;
    wire [LINK_SEL_W-1:0]  cmd_dest_o;
    wire                   cmd_last_o;

    // Expected response of the access in flight
    logic                  exp_we;
    logic                  exp_err;
    logic                  fast_ack;
    logic [ADDR_W-1:0]     exp_addr;
    logic [DATA_W-1:0]     exp_wdata;
    logic [DATA_W-1:0]     exp_rdata;
    logic                  word_is_hdr;
    int                    outstanding;
    int                    err_cnt;

    turf_reg_top DUT (
        .ps_clk (ps_clk), .rst_n_i (rst_n), .bus_req_i (bus_req), .bus_we_i (bus_we),
        .bus_addr_i (bus_addr), .bus_wdata_i (bus_wdata), .link_up_i (link_up),
        .cmd_credit_i (cmd_credit), .resp_valid_i (resp_valid), .resp_data_i (resp_data),
        .bus_ack_o (bus_ack_o), .bus_err_o (bus_err_o), .bus_rdata_o (bus_rdata_o),
        .cmd_valid_o (cmd_valid_o), .cmd_data_o (cmd_data_o), .cmd_dest_o (cmd_dest_o),
        .cmd_last_o (cmd_last_o)
    );

    crate_link_model #(.SEED(SEED)) u_link (
        .ps_clk (ps_clk), .rst_n_i (rst_n), .mute_i (mute), .cmd_valid_i (cmd_valid_o),
        .cmd_data_i (cmd_data_o), .cmd_dest_i (cmd_dest_o), .cmd_last_i (cmd_last_o),
        .credit_o (cmd_credit), .resp_valid_o (resp_valid), .resp_data_o (resp_data)
    );

    initial begin
        ps_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ps_clk = ~ps_clk;
    end

    // Stream framing and words in flight toward the far end
    always @(posedge ps_clk or negedge rst_n) begin
        if (!rst_n) begin
            word_is_hdr <= 1'b1;
            outstanding <= 0;
        end else begin
            if (cmd_valid_o) begin
                word_is_hdr <= cmd_last_o;
            end
            outstanding <= outstanding + int'(cmd_valid_o) - int'(cmd_credit);
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////

    ack_value : assert property (@(posedge ps_clk) disable iff (!rst_n)
        bus_ack_o |-> bus_err_o == exp_err && (exp_we || bus_rdata_o == exp_rdata))
    else begin
        err_cnt++;
        $display("Fail %0t: ack err=%0b rdata=%h, expected err=%0b rdata=%h", $time,
                 $sampled(bus_err_o), $sampled(bus_rdata_o), exp_err, exp_rdata);
    end

    ack_latency : assert property (@(posedge ps_clk) disable iff (!rst_n)
        $rose(bus_req) && fast_ack |=> bus_ack_o)
    else begin
        err_cnt++;
        $display("Fail %0t: ack not one cycle after req", $time);
    end

    no_cmd_words : assert property (@(posedge ps_clk) disable iff (!rst_n)
        bus_req && fast_ack |-> !cmd_valid_o)
    else begin
        err_cnt++;
        $display("Fail %0t: command word sent during a local or invalid access", $time);
    end

    header_fields : assert property (@(posedge ps_clk) disable iff (!rst_n)
        cmd_valid_o && word_is_hdr |-> cmd_data_o[DATA_W-1] == exp_we &&
            cmd_data_o[LINK_REG_W-1:0] == exp_addr[LINK_REG_W-1:0] &&
            cmd_dest_o == exp_addr[CRATE_ADDR_W-1 -: 2] && cmd_last_o == !exp_we)
    else begin
        err_cnt++;
        $display("Fail %0t: header %h dest %0d does not match the access", $time,
                 $sampled(cmd_data_o), $sampled(cmd_dest_o));
    end

    data_word : assert property (@(posedge ps_clk) disable iff (!rst_n)
        cmd_valid_o && !word_is_hdr |-> cmd_data_o == exp_wdata && cmd_last_o)
    else begin
        err_cnt++;
        $display("Fail %0t: write data word %h, expected %h", $time,
                 $sampled(cmd_data_o), exp_wdata);
    end

    credit_limit : assert property (@(posedge ps_clk) disable iff (!rst_n)
        outstanding <= CMD_CREDITS)
    else begin
        err_cnt++;
        $display("Fail %0t: %0d words in flight exceed the credits", $time, outstanding);
    end

    ////////////////////////////////////////////////////////////////////
    // Bus tasks
    ////////////////////////////////////////////////////////////////////

    task automatic bus_xfer(input logic we, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] rdata,
                            input logic err, input logic quick);
        @(negedge ps_clk);
        exp_we    = we;
        exp_addr  = addr;
        exp_wdata = wdata;
        exp_rdata = rdata;
        exp_err   = err;
        fast_ack  = quick;
        @(posedge ps_clk);
        bus_req   <= 1'b1;
        bus_we    <= we;
        bus_addr  <= addr;
        bus_wdata <= wdata;
        do @(negedge ps_clk); while (!bus_ack_o);
        @(posedge ps_clk);
        bus_req <= 1'b0;
    endtask

    function automatic logic [ADDR_W-1:0] crate_addr(input int link, input int reg_addr);
        return {1'b1, 2'(link), 25'(reg_addr)};
    endfunction

    task automatic local_read(input logic [13:0] off, input logic [DATA_W-1:0] exp,
                              input logic err);
        bus_xfer(1'b0, ADDR_W'(off), '0, exp, err, 1'b1);
    endtask

    task automatic local_write(input logic [13:0] off, input logic [DATA_W-1:0] data);
        bus_xfer(1'b1, ADDR_W'(off), data, '0, 1'b0, 1'b1);
    endtask

    initial begin
        rst_n = 1'b0;
        bus_req = 1'b0;
        bus_we = 1'b0;
        bus_addr = '0;
        bus_wdata = '0;
        link_up = 4'b1011;
        mute = 1'b0;
        exp_we = 1'b0;
        exp_err = 1'b0;
        fast_ack = 1'b0;
        exp_addr = '0;
        exp_wdata = '0;
        exp_rdata = '0;
        err_cnt = 0;
        repeat (3) @(posedge ps_clk);
        rst_n <= 1'b1;

        local_read(REG_IDENT, "TURF", 1'b0);
        local_read(REG_DATEVERSION, {1'b1, 15'h0A31, 4'd0, 4'd8, 8'd2}, 1'b0);
        local_read(14'h0020, '0, 1'b1);
        // Links 0 and 3 Aurora, link 1 none, link 2 Aurora but down
        local_write(REG_BRIDGE_TYPE, 32'h51);
        local_read(REG_BRIDGE_TYPE, 32'h51, 1'b0);
        local_read(REG_LINK_UP, 32'hB, 1'b0);

        bus_xfer(1'b1, crate_addr(0, 5), 32'h1234_5678, '0, 1'b0, 1'b0);
        bus_xfer(1'b0, crate_addr(0, 5), '0, 32'h1234_5678, 1'b0, 1'b0);
        bus_xfer(1'b1, crate_addr(3, 9), 32'hCAFE_0003, '0, 1'b0, 1'b0);
        bus_xfer(1'b0, crate_addr(3, 9), '0, 32'hCAFE_0003, 1'b0, 1'b0);

        bus_xfer(1'b0, crate_addr(1, 2), '0, 32'hDEADBEEF, 1'b1, 1'b1);
        bus_xfer(1'b0, crate_addr(2, 2), '0, 32'hDEADBEEF, 1'b1, 1'b1);
        local_read(REG_BRIDGE_STAT, 32'h600, 1'b0);
        local_write(REG_BRIDGE_STAT, 32'h600);
        local_read(REG_BRIDGE_STAT, 32'h0, 1'b0);

        mute <= 1'b1;
        bus_xfer(1'b0, crate_addr(0, 5), '0, 32'hBADC0FFE, 1'b1, 1'b0);
        mute <= 1'b0;
        local_read(REG_BRIDGE_STAT, 32'h1, 1'b0);
        local_write(REG_BRIDGE_STAT, 32'h1);
        bus_xfer(1'b0, crate_addr(0, 5), '0, 32'h1234_5678, 1'b0, 1'b0);

        // Back-to-back writes while the far end drains at random
        for (int i = 0; i < 8; i++) begin
            bus_xfer(1'b1, crate_addr((i % 2) * 3, i), 32'hA000_0000 + i * 32'h0101_0101,
                     '0, 1'b0, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            bus_xfer(1'b0, crate_addr((i % 2) * 3, i), '0,
                     32'hA000_0000 + i * 32'h0101_0101, 1'b0, 1'b0);
        end

        repeat (4) @(posedge ps_clk);
        $display("Errors: %0d failed checks", err_cnt);
        if (err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(NUM_TXN * (BRIDGE_TIMEOUT_CYCLES + 40) * CLK_PERIOD);
        $display("Watchdog expired with a bus access still open, %0d failed checks", err_cnt);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the register path testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_turf_reg -f project.f -o Vtb_turf_reg
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_turf_reg > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^>>> PASS$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== project.f ====
source/turf_pkg.sv
source/cmd_credit_tx.sv
source/crate_bridge.sv
source/turf_id_ctrl.sv
source/turf_reg_top.sv
verif/crate_link_model.sv
verif/tb_turf_reg.sv
